//--- hw/fight_consts.svh
`ifndef FIGHT_CONSTS_SVH
`define FIGHT_CONSTS_SVH

// Clock cycles per one-second tick
`define FIGHT_TICK_DIV 60

// Countdown length in seconds
`define FIGHT_COUNTDOWN 4

// Health at the start of a round
`define FIGHT_HEALTH_MAX 3'd5

// Seconds counter width
`define FIGHT_TIMER_W 7

// Number of players on the board
`define FIGHT_PLAYERS 2

`endif

//--- hw/fight_pkg.sv
`default_nettype none

package fight_pkg;

  // Match phase
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_countdown = 3'd1,
    st_fight     = 3'd2,
    st_p1_win    = 3'd3,
    st_p2_win    = 3'd4,
    st_draw      = 3'd5
  } game_state_e;

  // Message spelled on the four left digits
  typedef enum logic [2:0] {
    msg_one_player = 3'd0,
    msg_two_player = 3'd1,
    msg_ready      = 3'd2,
    msg_fight      = 3'd3,
    msg_p1_win     = 3'd4,
    msg_p2_win     = 3'd5,
    msg_draw       = 3'd6
  } hex_msg_e;

  typedef enum logic [1:0] {
    tmr_hold  = 2'd0,
    tmr_count = 2'd1,
    tmr_clear = 2'd2
  } timer_cmd_e;

endpackage

`default_nettype wire

//--- hw/fight_top.sv
`include "fight_consts.svh"
`default_nettype none

module fight_top import fight_pkg::*; (
  input  wire                         clk,
  input  wire                         reset,
  input  wire  [3:0]                  key,
  input  wire  [9:0]                  sw,
  output logic [6:0]                  hex0,
  output logic [6:0]                  hex1,
  output logic [6:0]                  hex2,
  output logic [6:0]                  hex3,
  output logic [6:0]                  hex4,
  output logic [6:0]                  hex5,
  output game_state_e                 game_state,
  output logic [`FIGHT_TIMER_W-1:0]   game_duration,
  output logic [2:0]                  health1,
  output logic [2:0]                  health2
);

  logic       start_press;
  logic       one_player;
  timer_cmd_e timer_cmd;
  hex_msg_e   hex_msg;

  player_if players [`FIGHT_PLAYERS] ();  // Index 0 is player one

  input_conditioner i_cond (
    .clk         (clk),
    .reset       (reset),
    .key         (key),
    .sw          (sw),
    .start_press (start_press),
    .one_player  (one_player),
    .players     (players)
  );

  for (genvar i = 0; i < `FIGHT_PLAYERS; i++) begin : g_player
    player_unit i_unit (
      .clk   (clk),
      .reset (reset),
      .p     (players[i])
    );
  end

  game_ctrl i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .start_press (start_press),
    .one_player  (one_player),
    .seconds     (game_duration),
    .players     (players),
    .state       (game_state),
    .timer_cmd   (timer_cmd),
    .msg         (hex_msg)
  );

  round_timer i_timer (
    .clk     (clk),
    .reset   (reset),
    .cmd     (timer_cmd),
    .seconds (game_duration)
  );

  hex_display i_hex (
    .msg     (hex_msg),
    .seconds (game_duration),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

  assign health1 = players[0].health;
  assign health2 = players[1].health;

endmodule

`default_nettype wire

//--- hw/game_ctrl.sv
`include "fight_consts.svh"
`default_nettype none

module game_ctrl import fight_pkg::*; (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              start_press,
  input  wire                              one_player,
  input  wire  logic [`FIGHT_TIMER_W-1:0]  seconds,
  player_if.ctrl                           players [`FIGHT_PLAYERS],
  output game_state_e                      state,
  output timer_cmd_e                       timer_cmd,
  output hex_msg_e                         msg
);

  localparam logic [`FIGHT_TIMER_W-1:0] COUNTDOWN_SEC = `FIGHT_TIMER_W'(`FIGHT_COUNTDOWN);

  game_state_e               next_state;
  logic [`FIGHT_PLAYERS-1:0] ko;
  logic                      round_start;
  logic                      entering_round;

  for (genvar i = 0; i < `FIGHT_PLAYERS; i++) begin : g_link
    assign ko[i]                 = players[i].ko;
    assign players[i].round_start = round_start;
    assign players[i].fight       = (state == st_fight);
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (start_press) next_state = st_countdown;
      end
      st_countdown: begin
        if (seconds == COUNTDOWN_SEC) next_state = st_fight;
      end
      st_fight: begin
        if (&ko) begin
          next_state = st_draw;  // Double knockout wins over either side
        end else if (ko[0]) begin
          next_state = st_p2_win;
        end else if (ko[1]) begin
          next_state = st_p1_win;
        end
      end
      st_p1_win, st_p2_win, st_draw: begin
        if (start_press) next_state = st_idle;
      end
      default: next_state = st_idle;
    endcase
  end

  assign entering_round = (next_state != state) &&
                          (next_state == st_countdown || next_state == st_fight);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= st_idle;
      timer_cmd   <= tmr_clear;
      round_start <= 1'b0;
    end else begin
      state       <= next_state;
      round_start <= entering_round;
      if (entering_round) begin
        timer_cmd <= tmr_clear;  // Phase starts from zero seconds
      end else begin
        case (next_state)
          st_countdown, st_fight:        timer_cmd <= tmr_count;
          st_p1_win, st_p2_win, st_draw: timer_cmd <= tmr_hold;
          default:                       timer_cmd <= tmr_clear;
        endcase
      end
    end
  end

  always_comb begin
    case (state)
      st_idle:      msg = one_player ? msg_one_player : msg_two_player;
      st_countdown: msg = msg_ready;
      st_fight:     msg = msg_fight;
      st_p1_win:    msg = msg_p1_win;
      st_p2_win:    msg = msg_p2_win;
      st_draw:      msg = msg_draw;
      default:      msg = msg_two_player;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/hex_display.sv
`include "fight_consts.svh"
`default_nettype none

module hex_display import fight_pkg::*; (
  input  wire  hex_msg_e                  msg,
  input  wire  [`FIGHT_TIMER_W-1:0]       seconds,
  output logic [6:0]                      hex0,
  output logic [6:0]                      hex1,
  output logic [6:0]                      hex2,
  output logic [6:0]                      hex3,
  output logic [6:0]                      hex4,
  output logic [6:0]                      hex5
);

  // Active-low letter patterns, segment a is bit 0
  localparam logic [6:0] SEG_BLANK = 7'h7F;
  localparam logic [6:0] SEG_1     = 7'h79;
  localparam logic [6:0] SEG_2     = 7'h24;
  localparam logic [6:0] SEG_P     = 7'h0C;
  localparam logic [6:0] SEG_R     = 7'h2F;  // Lower-case r
  localparam logic [6:0] SEG_E     = 7'h06;
  localparam logic [6:0] SEG_D     = 7'h21;  // Lower-case d
  localparam logic [6:0] SEG_Y     = 7'h11;
  localparam logic [6:0] SEG_F     = 7'h0E;
  localparam logic [6:0] SEG_G     = 7'h42;
  localparam logic [6:0] SEG_T     = 7'h07;  // Lower-case t
  localparam logic [6:0] SEG_U     = 7'h41;  // Stands in for W
  localparam logic [6:0] SEG_N     = 7'h2B;
  localparam logic [6:0] SEG_A     = 7'h08;
  localparam logic [`FIGHT_TIMER_W-1:0] TEN = `FIGHT_TIMER_W'(10);

  logic [3:0] tens;
  logic [3:0] units;

  function automatic logic [6:0] digit_seg(input logic [3:0] d);
    logic [6:0] seg;
    case (d)
      4'd0:    seg = 7'h40;
      4'd1:    seg = 7'h79;
      4'd2:    seg = 7'h24;
      4'd3:    seg = 7'h30;
      4'd4:    seg = 7'h19;
      4'd5:    seg = 7'h12;
      4'd6:    seg = 7'h02;
      4'd7:    seg = 7'h78;
      4'd8:    seg = 7'h00;
      4'd9:    seg = 7'h10;
      default: seg = SEG_BLANK;
    endcase
    return seg;
  endfunction

  // Seconds never exceed 99
  assign tens  = 4'(seconds / TEN);
  assign units = 4'(seconds % TEN);
  assign hex1  = digit_seg(tens);
  assign hex0  = digit_seg(units);

  always_comb begin
    case (msg)
      msg_one_player: {hex5, hex4, hex3, hex2} = {SEG_1, SEG_P, SEG_BLANK, SEG_BLANK};
      msg_two_player: {hex5, hex4, hex3, hex2} = {SEG_2, SEG_P, SEG_BLANK, SEG_BLANK};
      msg_ready:      {hex5, hex4, hex3, hex2} = {SEG_R, SEG_E, SEG_D, SEG_Y};
      msg_fight:      {hex5, hex4, hex3, hex2} = {SEG_F, SEG_1, SEG_G, SEG_T};
      msg_p1_win:     {hex5, hex4, hex3, hex2} = {SEG_P, SEG_1, SEG_U, SEG_N};
      msg_p2_win:     {hex5, hex4, hex3, hex2} = {SEG_P, SEG_2, SEG_U, SEG_N};
      msg_draw:       {hex5, hex4, hex3, hex2} = {SEG_D, SEG_R, SEG_A, SEG_U};
      default:        {hex5, hex4, hex3, hex2} = {4{SEG_BLANK}};
    endcase
  end

endmodule

`default_nettype wire

//--- hw/input_conditioner.sv
`include "fight_consts.svh"
`default_nettype none

module input_conditioner (
  input  wire        clk,
  input  wire        reset,
  input  wire  [3:0] key,
  input  wire  [9:0] sw,
  output logic       start_press,
  output logic       one_player,
  player_if.source   players [`FIGHT_PLAYERS]
);

  // Only keys 0..2 and switches 0..2 are used by the game
  logic [2:0] key_s1;
  logic [2:0] key_s2;
  logic [2:0] key_prev;
  logic [2:0] press;
  logic [2:0] sw_s1;
  logic [2:0] sw_s2;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      key_s1   <= 3'b111;  // Keys idle high
      key_s2   <= 3'b111;
      key_prev <= 3'b111;
      press    <= 3'b000;
    end else begin
      key_s1   <= key[2:0];
      key_s2   <= key_s1;
      key_prev <= key_s2;
      press    <= key_prev & ~key_s2;  // Falling edge of active-low key
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sw_s1 <= 3'b000;
      sw_s2 <= 3'b000;
    end else begin
      sw_s1 <= sw[2:0];
      sw_s2 <= sw_s1;
    end
  end

  assign start_press = press[0];
  assign one_player  = sw_s2[0];

  // Each attack key lands on the opponent
  assign players[1].hit   = press[1];  // Player one attacks player two
  assign players[0].hit   = press[2];  // Player two attacks player one
  assign players[0].block = sw_s2[1];
  assign players[1].block = sw_s2[2];

endmodule

`default_nettype wire

//--- hw/player_if.sv
`default_nettype none

interface player_if;

  logic       hit;          // Attack landed on this player, one cycle
  logic       block;        // Block switch level
  logic       round_start;  // Reload health
  logic       fight;        // Fight phase active
  logic [2:0] health;
  logic       ko;           // Health reached zero

  modport source (
    output hit,
    output block
  );

  modport ctrl (
    output round_start,
    output fight,
    input  ko
  );

  modport unit (
    input  hit,
    input  block,
    input  round_start,
    input  fight,
    output health,
    output ko
  );

endinterface

`default_nettype wire

//--- hw/player_unit.sv
`include "fight_consts.svh"
`default_nettype none

module player_unit (
  input wire    clk,
  input wire    reset,
  player_if.unit p
);

  logic [2:0] health;
  logic       hit_ok;

  // A hit counts only in the fight, unblocked, while still standing
  assign hit_ok = p.hit && p.fight && !p.block && (health != 3'd0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      health <= `FIGHT_HEALTH_MAX;
    end else if (p.round_start) begin
      health <= `FIGHT_HEALTH_MAX;  // New round
    end else if (hit_ok) begin
      health <= health - 3'd1;
    end
  end

  assign p.health = health;
  assign p.ko     = (health == 3'd0);

endmodule

`default_nettype wire

//--- hw/round_timer.sv
`include "fight_consts.svh"
`default_nettype none

module round_timer import fight_pkg::*; (
  input  wire                             clk,
  input  wire                             reset,
  input  wire  timer_cmd_e                cmd,
  output logic [`FIGHT_TIMER_W-1:0]       seconds
);

  localparam int DIV_W = $clog2(`FIGHT_TICK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`FIGHT_TICK_DIV - 1);
  localparam logic [`FIGHT_TIMER_W-1:0] SEC_MAX = `FIGHT_TIMER_W'(99);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;

  assign tick = (div_cnt == DIV_LAST);  // One cycle per second

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
      seconds <= '0;
    end else begin
      case (cmd)
        tmr_clear: begin
          div_cnt <= '0;
          seconds <= '0;
        end
        tmr_count: begin
          if (tick) begin
            div_cnt <= '0;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
          if (tick && seconds != SEC_MAX) begin
            seconds <= seconds + 1'b1;  // Saturates for two digits
          end
        end
        default: begin
          div_cnt <= div_cnt;  // Hold freezes both
          seconds <= seconds;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/fight_pkg.sv
hw/player_if.sv
hw/input_conditioner.sv
hw/player_unit.sv
hw/round_timer.sv
hw/game_ctrl.sv
hw/hex_display.sv
hw/fight_top.sv
test/fight_tb.sv

//--- test/fight_tb.sv
`include "fight_consts.svh"
`default_nettype none

module fight_tb import fight_pkg::*; ();

  // Active-low segment patterns, segment a is bit 0
  localparam logic [6:0] LET_1     = 7'h79;
  localparam logic [6:0] LET_2     = 7'h24;
  localparam logic [6:0] LET_P     = 7'h0C;
  localparam logic [6:0] LET_BLANK = 7'h7F;

  logic                      clk;
  logic                      reset;
  logic [3:0]                key;
  logic [9:0]                sw;
  logic [6:0]                hex0;
  logic [6:0]                hex1;
  logic [6:0]                hex2;
  logic [6:0]                hex3;
  logic [6:0]                hex4;
  logic [6:0]                hex5;
  game_state_e               game_state;
  logic [`FIGHT_TIMER_W-1:0] game_duration;
  logic [2:0]                health1;
  logic [2:0]                health2;

  int          value_errors;
  int          other_failures;
  logic [31:0] rng;
  int          hits;  // Random hit count of the damage test

  fight_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .key           (key),
    .sw            (sw),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5),
    .game_state    (game_state),
    .game_duration (game_duration),
    .health1       (health1),
    .health2       (health2)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [6:0] digit_pattern(input int d);
    logic [6:0] seg;
    case (d)
      0:       seg = 7'h40;
      1:       seg = 7'h79;
      2:       seg = 7'h24;
      3:       seg = 7'h30;
      4:       seg = 7'h19;
      5:       seg = 7'h12;
      6:       seg = 7'h02;
      7:       seg = 7'h78;
      8:       seg = 7'h00;
      9:       seg = 7'h10;
      default: seg = LET_BLANK;
    endcase
    return seg;
  endfunction

  task automatic check_state(input game_state_e got, input game_state_e exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] game_state: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_health(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_seconds(input logic [6:0] got, input logic [6:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] game_duration: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_digit(input string name, input logic [6:0] got, input logic [6:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic wait_for_state(input game_state_e exp, input int limit);
    int cycles;
    cycles = 0;
    while (game_state !== exp && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (game_state !== exp) begin
      other_failures++;
      $display("Timeout: game state did not become %h within %0d cycles", exp, limit);
    end
  endtask

  task automatic wait_state_left(input game_state_e cur, input int limit);
    int cycles;
    cycles = 0;
    while (game_state === cur && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (game_state === cur) begin
      other_failures++;
      $display("Timeout: game state stayed at %h for %0d cycles", cur, limit);
    end
  endtask

  task automatic wait_for_duration(input logic [6:0] exp, input int limit);
    int cycles;
    cycles = 0;
    while (game_duration !== exp && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (game_duration !== exp) begin
      other_failures++;
      $display("Timeout: game duration did not reach %0d within %0d cycles", exp, limit);
    end
  endtask

  // Holds the masked keys low for 4 cycles, then lets the release settle
  task automatic press_keys(input logic [3:0] mask);
    @(posedge clk);
    key <= ~mask;
    repeat (4) @(posedge clk);
    key <= 4'hF;
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic press_times(input logic [3:0] mask, input int n);
    for (int i = 0; i < n; i++) begin
      press_keys(mask);
    end
  endtask

  task automatic set_switches(input logic [9:0] value);
    @(posedge clk);
    sw <= value;
    repeat (3) @(posedge clk);  // Two synchronizer stages
    @(negedge clk);
  endtask

  // Key 0 press, countdown, then the fight entered at 4 seconds
  task automatic start_round();
    press_keys(4'b0001);
    wait_for_state(st_countdown, 20);
    check_health("health1", health1, 3'd5);
    check_health("health2", health2, 3'd5);
    wait_for_state(st_fight, 300);
    check_seconds(game_duration, 7'd4);
  endtask

  task automatic test_reset();
    check_state(game_state, st_idle);
    check_health("health1", health1, 3'd5);
    check_health("health2", health2, 3'd5);
    check_seconds(game_duration, 7'd0);
    check_digit("hex0", hex0, digit_pattern(0));
    check_digit("hex5", hex5, LET_2);  // Switch 0 low selects two players
    check_digit("hex4", hex4, LET_P);
    check_digit("hex3", hex3, LET_BLANK);
    check_digit("hex2", hex2, LET_BLANK);
    set_switches(10'b0000000001);
    check_digit("hex5", hex5, LET_1);
    check_digit("hex4", hex4, LET_P);
    check_digit("hex3", hex3, LET_BLANK);
    check_digit("hex2", hex2, LET_BLANK);
    set_switches(10'b0000000000);
  endtask

  task automatic test_countdown();
    start_round();
    @(negedge clk);
    check_seconds(game_duration, 7'd0);  // Cleared for the fight phase
    wait_for_duration(7'd1, 2 * `FIGHT_TICK_DIV);
    check_digit("hex1", hex1, digit_pattern(0));
    check_digit("hex0", hex0, digit_pattern(1));
  endtask

  task automatic test_damage();
    rng = xorshift32(rng);
    hits = int'(rng % 32'd4) + 1;
    press_times(4'b0010, hits);
    check_health("health2", health2, 3'(5 - hits));
    check_health("health1", health1, 3'd5);
    set_switches(10'b0000000010);  // Player one blocks
    press_times(4'b0100, 2);
    check_health("health1", health1, 3'd5);
    set_switches(10'b0000000000);
  endtask

  task automatic test_win_return();
    logic [6:0] frozen;
    press_times(4'b0010, 5 - hits);
    check_health("health2", health2, 3'd0);
    wait_for_state(st_p1_win, 20);
    frozen = game_duration;
    repeat (200) @(negedge clk);
    check_seconds(game_duration, frozen);
    press_keys(4'b0010);
    press_keys(4'b0100);
    check_health("health1", health1, 3'd5);
    check_health("health2", health2, 3'd0);
    press_keys(4'b0001);
    wait_for_state(st_idle, 20);
  endtask

  task automatic test_second_round();
    start_round();
    press_times(4'b0100, 5);
    wait_for_state(st_p2_win, 20);
    check_health("health1", health1, 3'd0);
    check_health("health2", health2, 3'd5);
    press_keys(4'b0001);
    wait_for_state(st_idle, 20);
  endtask

  task automatic test_draw();
    start_round();
    press_times(4'b0010, 4);
    press_times(4'b0100, 4);
    check_health("health1", health1, 3'd1);
    check_health("health2", health2, 3'd1);
    check_state(game_state, st_fight);
    press_keys(4'b0110);  // Both attacks in the same cycle
    wait_state_left(st_fight, 20);
    check_state(game_state, st_draw);
    check_health("health1", health1, 3'd0);
    check_health("health2", health2, 3'd0);
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    key            = 4'hF;
    sw             = '0;
    value_errors   = 0;
    other_failures = 0;
    rng            = 32'hc5f0;
    hits           = 1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset();
    test_countdown();
    test_damage();
    test_win_return();
    test_second_round();
    test_draw();
    $display("Value errors: %0d, other failures: %0d", value_errors, other_failures);
    if (value_errors == 0 && other_failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
